//--- common/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // low bit of each instruction field
    localparam int OP_LSB   = 26;
    localparam int RS_LSB   = 21;
    localparam int RT_LSB   = 16;
    localparam int RD_LSB   = 11;
    localparam int SA_LSB   = 6;
    localparam int FUNC_LSB = 0;
    localparam int IMM_LSB  = 0;
    localparam int JIDX_LSB = 0;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam reg_idx_t REG_LINK = 5'd31;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

    // one-hot alu operation select
    typedef logic [11:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef logic [4:0] excode_t;

    localparam excode_t EX_NO   = 5'd0;
    localparam excode_t EX_ADEL = 5'd4;
    localparam excode_t EX_RI   = 5'd10;

    // jal return address is pc + 8 past the delay slot
    localparam int LINK_OFFSET = 8;

endpackage

//--- verilog/regfile.sv
module regfile import isa_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    output word_t    rdata1,
    input  reg_idx_t raddr2,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

//--- id_stage/stage_latch.sv
module stage_latch import isa_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  fs_to_ds_valid,
    input  word_t fs_pc,
    input  word_t fs_inst,
    input  logic  fs_ex,
    input  logic  ready_go,
    input  logic  es_allowin,
    input  logic  ws_flush,
    output logic  ds_allowin,
    output logic  ds_valid,
    output logic  ds_to_es_valid,
    output word_t ds_pc,
    output word_t ds_inst,
    output logic  ds_fetch_ex
);

    // accept when empty or when the current one leaves this cycle
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go && !ws_flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_pc       <= fs_pc;
            ds_inst     <= fs_inst;
            ds_fetch_ex <= fs_ex;
        end
    end

endmodule

//--- id_stage/inst_decoder.sv
module inst_decoder import isa_pkg::*, pipe_pkg::*; (
    input  word_t       ds_inst,
    output alu_op_t     alu_op,
    output logic        src1_is_sa,
    output logic        src1_is_pc,
    output logic        src2_is_imm,
    output logic        src2_is_uimm,
    output logic        src2_is_8,
    output logic        res_from_mem,
    output logic        gr_we,
    output logic        mem_we,
    output reg_idx_t    dest,
    output reg_idx_t    rs,
    output reg_idx_t    rt,
    output logic [15:0] imm,
    output logic [25:0] jidx,
    output logic        is_beq,
    output logic        is_bne,
    output logic        is_jr,
    output logic        is_jump_abs,
    output logic        reserved
);

    logic [5:0] op;
    logic [5:0] func;
    reg_idx_t   rd;
    reg_idx_t   sa;
    logic       special;
    logic       r_nosa;
    logic       r_nors;
    logic       inst_addu, inst_subu, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_sll, inst_srl, inst_sra, inst_jr;
    logic       inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori;
    logic       inst_lui, inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;
    logic       dst_is_rt;

    assign op   = ds_inst[OP_LSB +: 6];
    assign rs   = ds_inst[RS_LSB +: 5];
    assign rt   = ds_inst[RT_LSB +: 5];
    assign rd   = ds_inst[RD_LSB +: 5];
    assign sa   = ds_inst[SA_LSB +: 5];
    assign func = ds_inst[FUNC_LSB +: 6];
    assign imm  = ds_inst[IMM_LSB +: 16];
    assign jidx = ds_inst[JIDX_LSB +: 26];

    assign special = (op == OP_SPECIAL);
    // register forms use sa == 0 and constant shifts use rs == 0
    assign r_nosa  = special && (sa == 5'd0);
    assign r_nors  = special && (rs == 5'd0);

    assign inst_addu  = r_nosa && (func == FN_ADDU);
    assign inst_subu  = r_nosa && (func == FN_SUBU);
    assign inst_slt   = r_nosa && (func == FN_SLT);
    assign inst_sltu  = r_nosa && (func == FN_SLTU);
    assign inst_and   = r_nosa && (func == FN_AND);
    assign inst_or    = r_nosa && (func == FN_OR);
    assign inst_xor   = r_nosa && (func == FN_XOR);
    assign inst_nor   = r_nosa && (func == FN_NOR);
    assign inst_sll   = r_nors && (func == FN_SLL);
    assign inst_srl   = r_nors && (func == FN_SRL);
    assign inst_sra   = r_nors && (func == FN_SRA);
    assign inst_jr    = r_nosa && (func == FN_JR) && (rt == 5'd0) && (rd == 5'd0);
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && (rs == 5'd0);
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign inst_beq   = (op == OP_BEQ);
    assign inst_bne   = (op == OP_BNE);
    assign inst_j     = (op == OP_J);
    assign inst_jal   = (op == OP_JAL);

    always_comb begin
        alu_op           = '0;
        alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        alu_op[ALU_SUB]  = inst_subu;
        alu_op[ALU_SLT]  = inst_slt | inst_slti;
        alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
        alu_op[ALU_AND]  = inst_and | inst_andi;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or | inst_ori;
        alu_op[ALU_XOR]  = inst_xor | inst_xori;
        alu_op[ALU_SLL]  = inst_sll;
        alu_op[ALU_SRL]  = inst_srl;
        alu_op[ALU_SRA]  = inst_sra;
        alu_op[ALU_LUI]  = inst_lui;
    end

    assign src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc   = inst_jal;
    assign src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign src2_is_uimm = inst_andi | inst_ori | inst_xori;
    assign src2_is_8    = inst_jal;
    assign res_from_mem = inst_lw;
    assign mem_we       = inst_sw;
    assign gr_we        = ~inst_sw & ~inst_beq & ~inst_bne & ~inst_j & ~inst_jr;

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | inst_lw;
    assign dest      = inst_jal  ? REG_LINK :
                       dst_is_rt ? rt       :
                                   rd;

    assign is_beq      = inst_beq;
    assign is_bne      = inst_bne;
    assign is_jr       = inst_jr;
    assign is_jump_abs = inst_j | inst_jal;

    assign reserved = !(inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                      | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | inst_jr
                      | inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                      | inst_xori | inst_lui | inst_lw | inst_sw | inst_beq | inst_bne
                      | inst_j | inst_jal);

endmodule

//--- id_stage/operand_bypass.sv
module operand_bypass import isa_pkg::*; (
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  word_t    rf_rdata1,
    input  word_t    rf_rdata2,
    input  logic     es_fwd_valid,
    input  logic     es_is_load,
    input  reg_idx_t es_dest,
    input  word_t    es_data,
    input  logic     ms_fwd_valid,
    input  reg_idx_t ms_dest,
    input  word_t    ms_data,
    input  logic     ws_we,
    input  reg_idx_t ws_dest,
    input  word_t    ws_data,
    output word_t    rs_value,
    output word_t    rt_value,
    output logic     ready_go
);

    // nearest producer wins and register 0 comes from the file
    function automatic word_t pick(input reg_idx_t src, input word_t rf_val);
        word_t val;
        if (src == 5'd0) begin
            val = rf_val;
        end else if (es_fwd_valid && !es_is_load && es_dest == src) begin
            val = es_data;
        end else if (ms_fwd_valid && ms_dest == src) begin
            val = ms_data;
        end else if (ws_we && ws_dest == src) begin
            val = ws_data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        rs_value = pick(rs, rf_rdata1);
        rt_value = pick(rt, rf_rdata2);
    end

    // load data not ready until memory stage
    assign ready_go = !(es_is_load && (es_dest != 5'd0) && (es_dest == rs || es_dest == rt));

endmodule

//--- id_stage/branch_unit.sv
module branch_unit import isa_pkg::*; (
    input  logic        ds_valid,
    input  word_t       ds_pc,
    input  logic        is_beq,
    input  logic        is_bne,
    input  logic        is_jr,
    input  logic        is_jump_abs,
    input  logic [15:0] imm,
    input  logic [25:0] jidx,
    input  word_t       rs_value,
    input  word_t       rt_value,
    output logic        br_taken,
    output word_t       br_target
);

    word_t seq_pc;
    word_t rel_target;
    logic  rs_eq_rt;

    // delay slot address
    assign seq_pc     = ds_pc + 32'd4;
    assign rel_target = seq_pc + {{14{imm[15]}}, imm, 2'b00};
    assign rs_eq_rt   = (rs_value == rt_value);

    assign br_taken = ds_valid && ((is_beq && rs_eq_rt) || (is_bne && !rs_eq_rt)
                                   || is_jr || is_jump_abs);

    assign br_target = (is_beq || is_bne) ? rel_target :
                       is_jr              ? rs_value   :
                                            {seq_pc[31:28], jidx, 2'b00};

endmodule

//--- id_stage/id_stage.sv
module id_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    // from fetch
    input  logic     fs_to_ds_valid,
    input  word_t    fs_pc,
    input  word_t    fs_inst,
    input  logic     fs_ex,
    output logic     ds_allowin,
    // to execute
    input  logic     es_allowin,
    output logic     ds_to_es_valid,
    output alu_op_t  alu_op,
    output logic     src1_is_sa,
    output logic     src1_is_pc,
    output logic     src2_is_imm,
    output logic     src2_is_uimm,
    output logic     src2_is_8,
    output logic     res_from_mem,
    output logic     gr_we,
    output logic     mem_we,
    output reg_idx_t dest,
    output logic [15:0] imm,
    output word_t    rs_value,
    output word_t    rt_value,
    output word_t    ds_pc,
    output logic     ds_ex,
    output excode_t  ds_excode,
    // to fetch
    output logic     br_taken,
    output word_t    br_target,
    // forwarding sources
    input  logic     es_fwd_valid,
    input  logic     es_is_load,
    input  reg_idx_t es_dest,
    input  word_t    es_data,
    input  logic     ms_fwd_valid,
    input  reg_idx_t ms_dest,
    input  word_t    ms_data,
    input  logic     ws_we,
    input  reg_idx_t ws_dest,
    input  word_t    ws_data,
    input  logic     ws_flush
);

    logic        ds_valid;
    logic        ready_go;
    logic        ds_fetch_ex;
    word_t       ds_inst;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [25:0] jidx;
    logic        is_beq;
    logic        is_bne;
    logic        is_jr;
    logic        is_jump_abs;
    logic        reserved;
    word_t       rf_rdata1;
    word_t       rf_rdata2;

    stage_latch u_latch (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_ex          (fs_ex),
        .ready_go       (ready_go),
        .es_allowin     (es_allowin),
        .ws_flush       (ws_flush),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_pc          (ds_pc),
        .ds_inst        (ds_inst),
        .ds_fetch_ex    (ds_fetch_ex)
    );

    inst_decoder u_decoder (
        .ds_inst      (ds_inst),
        .alu_op       (alu_op),
        .src1_is_sa   (src1_is_sa),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .src2_is_uimm (src2_is_uimm),
        .src2_is_8    (src2_is_8),
        .res_from_mem (res_from_mem),
        .gr_we        (gr_we),
        .mem_we       (mem_we),
        .dest         (dest),
        .rs           (rs),
        .rt           (rt),
        .imm          (imm),
        .jidx         (jidx),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_jr        (is_jr),
        .is_jump_abs  (is_jump_abs),
        .reserved     (reserved)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .rdata1 (rf_rdata1),
        .raddr2 (rt),
        .rdata2 (rf_rdata2),
        .we     (ws_we),
        .waddr  (ws_dest),
        .wdata  (ws_data)
    );

    operand_bypass u_bypass (
        .rs           (rs),
        .rt           (rt),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .es_fwd_valid (es_fwd_valid),
        .es_is_load   (es_is_load),
        .es_dest      (es_dest),
        .es_data      (es_data),
        .ms_fwd_valid (ms_fwd_valid),
        .ms_dest      (ms_dest),
        .ms_data      (ms_data),
        .ws_we        (ws_we),
        .ws_dest      (ws_dest),
        .ws_data      (ws_data),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .ready_go     (ready_go)
    );

    branch_unit u_branch (
        .ds_valid    (ds_valid),
        .ds_pc       (ds_pc),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .is_jr       (is_jr),
        .is_jump_abs (is_jump_abs),
        .imm         (imm),
        .jidx        (jidx),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

    assign ds_ex = ds_valid && (ds_fetch_ex || reserved);

    // address error from fetch takes priority
    assign ds_excode = ds_fetch_ex ? EX_ADEL :
                       reserved    ? EX_RI   :
                                     EX_NO;

endmodule

//--- tests/id_stage_checks.svh
`ifndef ID_STAGE_CHECKS_SVH
`define ID_STAGE_CHECKS_SVH

int error_count = 0;
int check_count = 0;

task automatic check_word(input string name, input word_t exp, input word_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
endtask

task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
endtask

task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
    end
endtask

task automatic check_excode(input string name, input excode_t exp, input excode_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
    end
endtask

`endif

//--- tests/tb_id_stage.sv
module tb_id_stage import isa_pkg::*, pipe_pkg::*; ();

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    // rough cycle budget of each test in run order
    localparam int TEST_CYCLES   = RESET_CYCLES + 2 + 20 + 20 + 14 + 20 + 16;
    localparam int MARGIN_CYCLES = 50;

    logic        clk;
    logic        reset;
    logic        fs_to_ds_valid;
    word_t       fs_pc;
    word_t       fs_inst;
    logic        fs_ex;
    logic        ds_allowin;
    logic        es_allowin;
    logic        ds_to_es_valid;
    alu_op_t     alu_op;
    logic        src1_is_sa;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        src2_is_uimm;
    logic        src2_is_8;
    logic        res_from_mem;
    logic        gr_we;
    logic        mem_we;
    reg_idx_t    dest;
    logic [15:0] imm;
    word_t       rs_value;
    word_t       rt_value;
    word_t       ds_pc;
    logic        ds_ex;
    excode_t     ds_excode;
    logic        br_taken;
    word_t       br_target;
    logic        es_fwd_valid;
    logic        es_is_load;
    reg_idx_t    es_dest;
    word_t       es_data;
    logic        ms_fwd_valid;
    reg_idx_t    ms_dest;
    word_t       ms_data;
    logic        ws_we;
    reg_idx_t    ws_dest;
    word_t       ws_data;
    logic        ws_flush;

    int test_count = 0;

    `include "id_stage_checks.svh"

    id_stage id_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t encode_r(input reg_idx_t s, input reg_idx_t t, input reg_idx_t d,
                                       input logic [4:0] sa, input logic [5:0] fn);
        return {OP_SPECIAL, s, t, d, sa, fn};
    endfunction

    function automatic word_t encode_i(input logic [5:0] op, input reg_idx_t s, input reg_idx_t t,
                                       input logic [15:0] k);
        return {op, s, t, k};
    endfunction

    function automatic word_t encode_j(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic alu_op_t alu_bit(input int b);
        return alu_op_t'(1) << b;
    endfunction

    task automatic settle();
        #10;
    endtask

    // waits for room in the stage, then hands over one instruction
    task automatic load_inst(input word_t inst, input word_t pc, input logic ex);
        @(negedge clk);
        while (!ds_allowin) @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_inst        = inst;
        fs_pc          = pc;
        fs_ex          = ex;
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        fs_ex          = 1'b0;
        settle();
    endtask

    task automatic write_reg(input reg_idx_t idx, input word_t val);
        @(negedge clk);
        ws_we   = 1'b1;
        ws_dest = idx;
        ws_data = val;
        @(negedge clk);
        ws_we   = 1'b0;
    endtask

    task automatic set_sources(input logic ev, input reg_idx_t ed, input word_t edata,
                               input logic mv, input reg_idx_t md, input word_t mdata,
                               input logic wv, input reg_idx_t wd, input word_t wdata);
        @(negedge clk);
        es_fwd_valid = ev;
        es_dest      = ed;
        es_data      = edata;
        ms_fwd_valid = mv;
        ms_dest      = md;
        ms_data      = mdata;
        ws_we        = wv;
        ws_dest      = wd;
        ws_data      = wdata;
        settle();
    endtask

    // flags follow the DUT port order
    task automatic expect_controls(input string tag, input alu_op_t e_alu,
                                   input logic e_sa, input logic e_pc, input logic e_imm,
                                   input logic e_uimm, input logic e_8, input logic e_mem,
                                   input logic e_we, input logic e_mw);
        check_alu_op({tag, ".alu_op"}, e_alu, alu_op);
        check_bit({tag, ".src1_is_sa"}, e_sa, src1_is_sa);
        check_bit({tag, ".src1_is_pc"}, e_pc, src1_is_pc);
        check_bit({tag, ".src2_is_imm"}, e_imm, src2_is_imm);
        check_bit({tag, ".src2_is_uimm"}, e_uimm, src2_is_uimm);
        check_bit({tag, ".src2_is_8"}, e_8, src2_is_8);
        check_bit({tag, ".res_from_mem"}, e_mem, res_from_mem);
        check_bit({tag, ".gr_we"}, e_we, gr_we);
        check_bit({tag, ".mem_we"}, e_mw, mem_we);
    endtask

    task automatic report_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("test %-10s ok", name);
        end else begin
            $display("test %-10s %0d errors", name, error_count - start_errors);
        end
    endtask

    task automatic test_reset();
        int start = error_count;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_bit("reset.ds_to_es_valid", 1'b0, ds_to_es_valid);
            check_bit("reset.br_taken", 1'b0, br_taken);
            check_bit("reset.ds_ex", 1'b0, ds_ex);
            check_bit("reset.ds_allowin", 1'b1, ds_allowin);
        end
        reset = 1'b0;
        settle();
        check_bit("reset.ds_to_es_valid", 1'b0, ds_to_es_valid);
        check_bit("reset.ds_allowin", 1'b1, ds_allowin);
        report_test("reset", start);
    endtask

    task automatic test_decode();
        int start = error_count;
        load_inst(encode_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h0000_0100, 1'b0);
        expect_controls("addu", alu_bit(ALU_ADD), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        check_reg_idx("addu.dest", 5'd3, dest);
        check_bit("addu.ds_to_es_valid", 1'b1, ds_to_es_valid);
        load_inst(encode_r(5'd4, 5'd5, 5'd6, 5'd0, FN_SUBU), 32'h0000_0104, 1'b0);
        expect_controls("subu", alu_bit(ALU_SUB), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        check_reg_idx("subu.dest", 5'd6, dest);
        load_inst(encode_r(5'd0, 5'd2, 5'd7, 5'd5, FN_SLL), 32'h0000_0108, 1'b0);
        expect_controls("sll", alu_bit(ALU_SLL), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        check_reg_idx("sll.dest", 5'd7, dest);
        load_inst(encode_i(OP_ADDIU, 5'd1, 5'd8, 16'hfffd), 32'h0000_010c, 1'b0);
        expect_controls("addiu", alu_bit(ALU_ADD), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        check_reg_idx("addiu.dest", 5'd8, dest);
        check_word("addiu.imm", 32'h0000_fffd, {16'h0, imm});
        load_inst(encode_i(OP_ANDI, 5'd1, 5'd9, 16'h00ff), 32'h0000_0110, 1'b0);
        expect_controls("andi", alu_bit(ALU_AND), 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        check_reg_idx("andi.dest", 5'd9, dest);
        load_inst(encode_i(OP_LUI, 5'd0, 5'd10, 16'h1234), 32'h0000_0114, 1'b0);
        expect_controls("lui", alu_bit(ALU_LUI), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        check_reg_idx("lui.dest", 5'd10, dest);
        check_word("lui.imm", 32'h0000_1234, {16'h0, imm});
        load_inst(encode_i(OP_LW, 5'd1, 5'd11, 16'h0008), 32'h0000_0118, 1'b0);
        expect_controls("lw", alu_bit(ALU_ADD), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        check_reg_idx("lw.dest", 5'd11, dest);
        load_inst(encode_i(OP_SW, 5'd1, 5'd2, 16'h000c), 32'h0000_011c, 1'b0);
        expect_controls("sw", alu_bit(ALU_ADD), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        check_word("sw.imm", 32'h0000_000c, {16'h0, imm});
        report_test("decode", start);
    endtask

    task automatic test_bypass();
        int start = error_count;
        write_reg(5'd1, 32'h1111_0001);
        write_reg(5'd2, 32'h2222_0002);
        // hold the instruction so the sources can change under it
        @(negedge clk);
        es_allowin = 1'b0;
        load_inst(encode_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h0000_0200, 1'b0);
        check_word("rf.rs_value", 32'h1111_0001, rs_value);
        check_word("rf.rt_value", 32'h2222_0002, rt_value);
        // same-cycle write back that also lands in r1
        set_sources(1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 1'b1, 5'd1, 32'h3333_0003);
        check_word("ws.rs_value", 32'h3333_0003, rs_value);
        check_word("ws.rt_value", 32'h2222_0002, rt_value);
        set_sources(1'b0, 5'd0, 32'h0, 1'b1, 5'd2, 32'h4444_0004, 1'b1, 5'd2, 32'h5555_0005);
        check_word("ms.rs_value", 32'h3333_0003, rs_value);
        check_word("ms.rt_value", 32'h4444_0004, rt_value);
        set_sources(1'b1, 5'd2, 32'h6666_0006, 1'b1, 5'd2, 32'h4444_0004,
                    1'b1, 5'd2, 32'h7777_0007);
        check_word("es.rs_value", 32'h3333_0003, rs_value);
        check_word("es.rt_value", 32'h6666_0006, rt_value);
        set_sources(1'b1, 5'd1, 32'h6666_0006, 1'b1, 5'd1, 32'h4444_0004, 1'b0, 5'd0, 32'h0);
        check_word("es_ms.rs_value", 32'h6666_0006, rs_value);
        check_word("es_ms.rt_value", 32'h7777_0007, rt_value);
        set_sources(1'b0, 5'd1, 32'h6666_0006, 1'b0, 5'd1, 32'h4444_0004, 1'b0, 5'd0, 32'h0);
        check_word("idle.rs_value", 32'h3333_0003, rs_value);
        check_word("idle.rt_value", 32'h7777_0007, rt_value);
        @(negedge clk);
        es_allowin = 1'b1;
        set_sources(1'b1, 5'd0, 32'hdead_0001, 1'b1, 5'd0, 32'hdead_0002,
                    1'b1, 5'd0, 32'hdead_0003);
        load_inst(encode_r(5'd0, 5'd0, 5'd3, 5'd0, FN_ADDU), 32'h0000_0204, 1'b0);
        check_word("r0.rs_value", 32'h0, rs_value);
        check_word("r0.rt_value", 32'h0, rt_value);
        set_sources(1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0);
        report_test("bypass", start);
    endtask

    task automatic test_stall();
        int start = error_count;
        @(negedge clk);
        es_fwd_valid = 1'b1;
        es_is_load   = 1'b1;
        es_dest      = 5'd1;
        load_inst(encode_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h0000_0500, 1'b0);
        check_bit("stall.ds_to_es_valid", 1'b0, ds_to_es_valid);
        check_bit("stall.ds_allowin", 1'b0, ds_allowin);
        // a newer instruction waits in fetch and must not get in
        @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_pc          = 32'h0000_0580;
        fs_inst        = encode_r(5'd7, 5'd8, 5'd9, 5'd0, FN_OR);
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        settle();
        check_word("stall.ds_pc", 32'h0000_0500, ds_pc);
        check_reg_idx("stall.dest", 5'd3, dest);
        check_bit("stall.ds_to_es_valid", 1'b0, ds_to_es_valid);
        @(negedge clk);
        es_is_load   = 1'b0;
        es_fwd_valid = 1'b0;
        settle();
        check_bit("release.ds_to_es_valid", 1'b1, ds_to_es_valid);
        check_bit("release.ds_allowin", 1'b1, ds_allowin);
        @(negedge clk);
        es_allowin = 1'b0;
        load_inst(encode_r(5'd4, 5'd5, 5'd6, 5'd0, FN_SUBU), 32'h0000_0504, 1'b0);
        check_bit("hold.ds_allowin", 1'b0, ds_allowin);
        check_bit("hold.ds_to_es_valid", 1'b1, ds_to_es_valid);
        @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_pc          = 32'h0000_0680;
        fs_inst        = encode_r(5'd7, 5'd8, 5'd9, 5'd0, FN_OR);
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        settle();
        check_word("hold.ds_pc", 32'h0000_0504, ds_pc);
        check_reg_idx("hold.dest", 5'd6, dest);
        check_bit("hold.ds_allowin", 1'b0, ds_allowin);
        @(negedge clk);
        es_allowin = 1'b1;
        settle();
        check_bit("accept.ds_allowin", 1'b1, ds_allowin);
        // taken by execute at this edge with nothing behind it
        @(negedge clk);
        settle();
        check_bit("empty.ds_to_es_valid", 1'b0, ds_to_es_valid);
        report_test("stall", start);
    endtask

    task automatic test_branch();
        int start = error_count;
        write_reg(5'd4, 32'h0000_0100);
        write_reg(5'd5, 32'h0000_0100);
        write_reg(5'd6, 32'h0000_0200);
        load_inst(encode_i(OP_BEQ, 5'd4, 5'd5, 16'h0010), 32'h0000_1000, 1'b0);
        check_bit("beq_eq.br_taken", 1'b1, br_taken);
        check_word("beq_eq.br_target", 32'h0000_1044, br_target);
        check_bit("beq_eq.gr_we", 1'b0, gr_we);
        load_inst(encode_i(OP_BEQ, 5'd4, 5'd6, 16'hfff0), 32'h0000_2000, 1'b0);
        check_bit("beq_ne.br_taken", 1'b0, br_taken);
        check_word("beq_ne.br_target", 32'h0000_1fc4, br_target);
        load_inst(encode_i(OP_BNE, 5'd4, 5'd6, 16'hfffe), 32'h0000_3000, 1'b0);
        check_bit("bne.br_taken", 1'b1, br_taken);
        check_word("bne.br_target", 32'h0000_2ffc, br_target);
        // pc + 4 crosses into the next 256 MB region
        load_inst(encode_j(OP_J, 26'h012_3456), 32'h4fff_fffc, 1'b0);
        check_bit("j.br_taken", 1'b1, br_taken);
        check_word("j.br_target", 32'h5048_d158, br_target);
        check_bit("j.gr_we", 1'b0, gr_we);
        load_inst(encode_j(OP_JAL, 26'h3ff_ffff), 32'h8000_0010, 1'b0);
        check_bit("jal.br_taken", 1'b1, br_taken);
        check_word("jal.br_target", 32'h8fff_fffc, br_target);
        expect_controls("jal", alu_bit(ALU_ADD), 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        check_reg_idx("jal.dest", REG_LINK, dest);
        load_inst(encode_r(5'd6, 5'd0, 5'd0, 5'd0, FN_JR), 32'h0000_0100, 1'b0);
        check_bit("jr.br_taken", 1'b1, br_taken);
        check_word("jr.br_target", 32'h0000_0200, br_target);
        check_bit("jr.gr_we", 1'b0, gr_we);
        report_test("branch", start);
    endtask

    task automatic test_exception();
        int start = error_count;
        load_inst({6'h3f, 26'h0}, 32'h0000_0600, 1'b0);
        check_bit("ri.ds_ex", 1'b1, ds_ex);
        check_excode("ri.ds_excode", EX_RI, ds_excode);
        load_inst({6'h3f, 26'h0}, 32'h0000_0604, 1'b1);
        check_bit("adel_ri.ds_ex", 1'b1, ds_ex);
        check_excode("adel_ri.ds_excode", EX_ADEL, ds_excode);
        load_inst(encode_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h0000_0608, 1'b1);
        check_bit("adel.ds_ex", 1'b1, ds_ex);
        check_excode("adel.ds_excode", EX_ADEL, ds_excode);
        load_inst(encode_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h0000_060c, 1'b0);
        check_bit("none.ds_ex", 1'b0, ds_ex);
        check_excode("none.ds_excode", EX_NO, ds_excode);
        @(negedge clk);
        es_allowin = 1'b0;
        load_inst(encode_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 32'h0000_0610, 1'b0);
        @(negedge clk);
        ws_flush = 1'b1;
        settle();
        check_bit("flush.ds_to_es_valid", 1'b0, ds_to_es_valid);
        @(negedge clk);
        ws_flush = 1'b0;
        settle();
        check_bit("unflush.ds_to_es_valid", 1'b1, ds_to_es_valid);
        @(negedge clk);
        es_allowin = 1'b1;
        report_test("exception", start);
    endtask

    initial begin
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_pc          = '0;
        fs_inst        = '0;
        fs_ex          = 1'b0;
        es_allowin     = 1'b1;
        es_fwd_valid   = 1'b0;
        es_is_load     = 1'b0;
        es_dest        = '0;
        es_data        = '0;
        ms_fwd_valid   = 1'b0;
        ms_dest        = '0;
        ms_data        = '0;
        ws_we          = 1'b0;
        ws_dest        = '0;
        ws_data        = '0;
        ws_flush       = 1'b0;
        test_reset();
        test_decode();
        test_bypass();
        test_stall();
        test_branch();
        test_exception();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: tests did not finish in %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- mips_decode.f
+incdir+tests
common/isa_pkg.sv
common/pipe_pkg.sv
verilog/regfile.sv
id_stage/stage_latch.sv
id_stage/inst_decoder.sv
id_stage/operand_bypass.sv
id_stage/branch_unit.sv
id_stage/id_stage.sv
tests/tb_id_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f mips_decode.f --top-module tb_id_stage -o tb_id_stage
./obj_dir/tb_id_stage | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "simulation ended without a summary"
    exit 1
fi
echo "simulation clean"
